/* design/enetAudioPkg.sv */
// Shared widths, chip register indices and timing constants
// Packed structs for one bus access, one init table step and the chip pins
`default_nettype none

package enetAudioPkg;

  // Sixteen-bit word on the chip data bus or toward the codec
  typedef logic [15:0] enetWord;
  typedef logic [15:0] byteCount;
  typedef logic [3:0]  initIndex;

  localparam int initSteps   = 12;
  localparam int delayCycles = 24;

  // Chip register indices and the values written during bring-up
  localparam enetWord regNetCtrlIdx    = 16'h0000;
  localparam enetWord netCtrlReset     = 16'h0001;
  localparam enetWord netCtrlRelease   = 16'h0000;
  localparam enetWord regPhyCtrlIdx    = 16'h001F;
  localparam enetWord phyPowerUp       = 16'h0000;
  localparam enetWord regRxCtrlIdx     = 16'h0005;
  localparam enetWord rxCtrlEnable     = 16'h0039;
  localparam enetWord regIntMaskIdx    = 16'h00FF;
  localparam enetWord intMaskEnable    = 16'h0081;
  localparam enetWord regRxStatusIdx   = 16'h00FE;
  localparam enetWord regRxStatusClear = 16'h003F;
  localparam enetWord regRxDataIdx     = 16'h00F2;

  typedef struct packed {
    logic    isWrite;
    logic    isData;
    enetWord wdata;
  } busOp;

  typedef struct packed {
    logic isDelay;
    busOp op;
  } initStep;

  typedef struct packed {
    enetWord dataOut;
    logic    cmd;
    logic    csN;
    logic    wrN;
    logic    rdN;
    logic    dataOutEnable;
  } enetPins;

endpackage

`default_nettype wire

/* design/enetInitRom.sv */
// Constant table of chip initialisation steps
// Address and data writes plus one wait for the PHY to power up
`default_nettype none

module enetInitRom (
  input  enetAudioPkg::initIndex stepIndex,
  output enetAudioPkg::initStep  step
);

  function automatic enetAudioPkg::initStep addrWrite(input enetAudioPkg::enetWord idx);
    return '{isDelay: 1'b0, op: '{isWrite: 1'b1, isData: 1'b0, wdata: idx}};
  endfunction

  function automatic enetAudioPkg::initStep dataWrite(input enetAudioPkg::enetWord val);
    return '{isDelay: 1'b0, op: '{isWrite: 1'b1, isData: 1'b1, wdata: val}};
  endfunction

  always_comb begin
    case (stepIndex)
      4'd0:    step = addrWrite(enetAudioPkg::regNetCtrlIdx);
      4'd1:    step = dataWrite(enetAudioPkg::netCtrlReset);
      // Same index stays selected, so the reset bit is simply cleared again
      4'd2:    step = dataWrite(enetAudioPkg::netCtrlRelease);
      4'd3:    step = addrWrite(enetAudioPkg::regPhyCtrlIdx);
      4'd4:    step = dataWrite(enetAudioPkg::phyPowerUp);
      4'd5:    step = '{isDelay: 1'b1, op: '0};
      4'd6:    step = addrWrite(enetAudioPkg::regRxStatusIdx);
      4'd7:    step = dataWrite(enetAudioPkg::regRxStatusClear);
      4'd8:    step = addrWrite(enetAudioPkg::regRxCtrlIdx);
      4'd9:    step = dataWrite(enetAudioPkg::rxCtrlEnable);
      4'd10:   step = addrWrite(enetAudioPkg::regIntMaskIdx);
      4'd11:   step = dataWrite(enetAudioPkg::intMaskEnable);
      default: step = '{isDelay: 1'b1, op: '0};
    endcase
  end

endmodule

`default_nettype wire

/* design/enetBusCycle.sv */
// Single chip register access over the asynchronous bus
// Setup, strobe and two hold clocks, then a four-phase ack back to the controller
`default_nettype none

module enetBusCycle (
  input  logic                  Clock,
  input  logic                  rstN,
  input  logic                  busReq,
  input  enetAudioPkg::busOp    busOp,
  output logic                  busAck,
  output enetAudioPkg::enetWord busRdata,
  input  enetAudioPkg::enetWord enetDataIn,
  output enetAudioPkg::enetPins pins
);

  typedef enum logic [2:0] {
    idle,
    setup,
    strobe,
    hold0,
    hold1,
    ackWait
  } cycleState;

  cycleState state;
  logic      active;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (busReq) state <= setup;
        setup:   state <= strobe;
        strobe:  state <= hold0;
        hold0:   state <= hold1;
        hold1:   state <= ackWait;
        ackWait: if (!busReq) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // The chip drives read data while rdN is low, so sample at the end of the strobe
  always_ff @(posedge Clock) begin
    if (state == strobe) busRdata <= enetDataIn;
  end

  assign active = (state == setup) || (state == strobe) || (state == hold0) || (state == hold1);
  assign busAck = (state == ackWait);

  always_comb begin
    pins.dataOut       = busOp.wdata;
    pins.cmd           = active && busOp.isData;
    pins.csN           = !active;
    pins.wrN           = !((state == strobe) && busOp.isWrite);
    pins.rdN           = !((state == strobe) && !busOp.isWrite);
    pins.dataOutEnable = (state != idle) && busOp.isWrite;
  end

endmodule

`default_nettype wire

/* design/enetRxControl.sv */
// Receive controller for the Ethernet chip
// Runs the init table, waits for packets, reads the header length
// and hands out byte-swapped payload words on the sample handshake
`default_nettype none

module enetRxControl (
  input  logic                   Clock,
  input  logic                   rstN,
  input  logic                   startInit,
  input  logic                   sampleReq,
  output logic                   sampleAck,
  output enetAudioPkg::enetWord  audioSample,
  input  logic                   enetInt,
  output enetAudioPkg::initIndex stepIndex,
  input  enetAudioPkg::initStep  step,
  output logic                   busReq,
  output enetAudioPkg::busOp     busOp,
  input  logic                   busAck,
  input  enetAudioPkg::enetWord  busRdata
);

  typedef enum logic [3:0] {
    idle,
    initIssue,
    initWait,
    initDelay,
    ready,
    headerIssue,
    headerWait,
    dataIssue,
    dataWait,
    ackHold
  } ctrlState;

  ctrlState               state;
  enetAudioPkg::initIndex stepCount;
  logic [6:0]             delayCount;
  logic [2:0]             headerStep;
  enetAudioPkg::byteCount remaining;
  logic                   delayDone;
  logic                   lastStep;
  enetAudioPkg::busOp     headerOp;
  enetAudioPkg::busOp     readOp;

  assign stepIndex = stepCount;
  assign lastStep  = (stepCount == enetAudioPkg::initIndex'(enetAudioPkg::initSteps - 1));

  // A pure delay step waits four times as long as a normal step
  assign delayDone = step.isDelay ? (delayCount == 7'(4 * enetAudioPkg::delayCycles - 1))
                                  : (delayCount == 7'(enetAudioPkg::delayCycles - 1));

  assign readOp = '{isWrite: 1'b0, isData: 1'b1, wdata: '0};

  // Header sequence clears the interrupt, then points at the receive buffer
  always_comb begin
    case (headerStep)
      3'd0:    headerOp = '{isWrite: 1'b1, isData: 1'b0, wdata: enetAudioPkg::regRxStatusIdx};
      3'd1:    headerOp = '{isWrite: 1'b1, isData: 1'b1, wdata: enetAudioPkg::regRxStatusClear};
      3'd2:    headerOp = '{isWrite: 1'b1, isData: 1'b0, wdata: enetAudioPkg::regRxDataIdx};
      default: headerOp = readOp;
    endcase
  end

  always_comb begin
    case (state)
      initIssue, initWait:     busOp = step.op;
      headerIssue, headerWait: busOp = headerOp;
      default:                 busOp = readOp;
    endcase
  end

  assign busReq = ((state == initIssue) && !step.isDelay) ||
                  (state == headerIssue) || (state == dataIssue);

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      state       <= idle;
      stepCount   <= '0;
      delayCount  <= '0;
      headerStep  <= '0;
      remaining   <= '0;
      sampleAck   <= 1'b0;
      audioSample <= '0;
    end else begin
      case (state)
        idle: begin
          if (startInit) begin
            stepCount <= '0;
            state     <= initIssue;
          end
        end
        initIssue: begin
          delayCount <= '0;
          if (step.isDelay) state <= initDelay;
          else if (busAck) state <= initWait;
        end
        initWait: if (!busAck) state <= initDelay;
        initDelay: begin
          delayCount <= delayCount + 7'd1;
          if (delayDone && lastStep) begin
            state <= ready;
          end else if (delayDone) begin
            stepCount <= stepCount + 4'd1;
            state     <= initIssue;
          end
        end
        ready: begin
          if (startInit) begin
            stepCount <= '0;
            state     <= initIssue;
          end else if (sampleReq && (remaining != '0)) begin
            state <= dataIssue;
          end else if (sampleReq && enetInt) begin
            headerStep <= '0;
            state      <= headerIssue;
          end else if (sampleReq) begin
            state <= ackHold;
          end
        end
        headerIssue: begin
          if (busAck) begin
            // Odd lengths lose their last byte
            if (headerStep == 3'd4) remaining <= {busRdata[15:1], 1'b0};
            state <= headerWait;
          end
        end
        headerWait: begin
          if (!busAck && (headerStep == 3'd4)) begin
            state <= dataIssue;
          end else if (!busAck) begin
            headerStep <= headerStep + 3'd1;
            state      <= headerIssue;
          end
        end
        dataIssue: begin
          if (busAck) begin
            audioSample <= {busRdata[7:0], busRdata[15:8]};
            remaining   <= (remaining > 16'd2) ? remaining - 16'd2 : '0;
            state       <= dataWait;
          end
        end
        dataWait: if (!busAck) state <= ackHold;
        ackHold: begin
          if (!sampleAck) begin
            sampleAck <= 1'b1;
          end else if (!sampleReq) begin
            sampleAck <= 1'b0;
            state     <= ready;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/enetAudioTop.sv */
// Top level of the audio receive path
// Joins the controller, the init table and the bus-cycle unit to the chip pins
`default_nettype none

module enetAudioTop (
  input  logic                  Clock,
  input  logic                  rstN,
  input  logic                  startInit,
  input  logic                  sampleReq,
  output logic                  sampleAck,
  output enetAudioPkg::enetWord audioSample,
  input  enetAudioPkg::enetWord enetDataIn,
  input  logic                  enetInt,
  output enetAudioPkg::enetPins pins,
  output logic                  enetRstN
);

  enetAudioPkg::initIndex stepIndex;
  enetAudioPkg::initStep  step;
  enetAudioPkg::busOp     busOp;
  enetAudioPkg::enetWord  busRdata;
  logic                   busReq;
  logic                   busAck;

  // The chip is held in reset together with the design
  assign enetRstN = rstN;

  enetRxControl rxControl (
    .Clock       (Clock),
    .rstN        (rstN),
    .startInit   (startInit),
    .sampleReq   (sampleReq),
    .sampleAck   (sampleAck),
    .audioSample (audioSample),
    .enetInt     (enetInt),
    .stepIndex   (stepIndex),
    .step        (step),
    .busReq      (busReq),
    .busOp       (busOp),
    .busAck      (busAck),
    .busRdata    (busRdata)
  );

  enetInitRom initRom (
    .stepIndex (stepIndex),
    .step      (step)
  );

  enetBusCycle busCycle (
    .Clock      (Clock),
    .rstN       (rstN),
    .busReq     (busReq),
    .busOp      (busOp),
    .busAck     (busAck),
    .busRdata   (busRdata),
    .enetDataIn (enetDataIn),
    .pins       (pins)
  );

endmodule

`default_nettype wire

/* bench/enetChipModel.sv */
// Behavioural model of the Ethernet chip on its asynchronous register bus
// Write log, receive header and payload reads, and the receive interrupt
`default_nettype none

module enetChipModel (
  input  enetAudioPkg::enetPins        pins,
  input  logic [7:0]                   pktSeq,
  input  enetAudioPkg::enetWord        pktLength,
  input  enetAudioPkg::enetWord [31:0] pktWords,
  output enetAudioPkg::enetWord        enetDataIn,
  output logic                         enetInt
);
  timeunit 1ns;
  timeprecision 1ps;

  // Each log entry holds the cmd level above the written data
  logic [16:0]           writeLog [0:255];
  logic [7:0]            logCount   = 8'd0;
  logic [7:0]            clearedSeq = 8'd0;
  enetAudioPkg::enetWord lastIndex  = 16'h0000;
  logic [1:0]            readPhase  = 2'd2;
  logic [4:0]            readPtr    = 5'd0;

  // A packet stays pending until a status clear catches up with its sequence number
  assign enetInt = (pktSeq != clearedSeq);

  // The first two reads after the data index return a status word and the length
  assign enetDataIn = (readPhase == 2'd0) ? 16'h0001 :
                      (readPhase == 2'd1) ? pktLength : pktWords[readPtr];

  // An access completes on the rising edge of its strobe
  always @(posedge pins.wrN or posedge pins.rdN) begin
    if (pins.dataOutEnable) begin
      writeLog[logCount] = {pins.cmd, pins.dataOut};
      logCount = logCount + 8'd1;
      if (!pins.cmd) begin
        lastIndex = pins.dataOut;
        if (pins.dataOut == enetAudioPkg::regRxDataIdx) begin
          readPhase = 2'd0;
          readPtr   = 5'd0;
        end
      end else if ((lastIndex == enetAudioPkg::regRxStatusIdx) &&
                   (pins.dataOut == enetAudioPkg::regRxStatusClear)) begin
        clearedSeq = pktSeq;
      end
    end else if (pins.cmd) begin
      if (readPhase < 2'd2) readPhase = readPhase + 2'd1;
      else readPtr = readPtr + 5'd1;
    end
  end

endmodule

`default_nettype wire

/* bench/enetAudioTb.sv */
// Testbench for the Ethernet audio receive path
// Clock, reset, watchdog, packet stimulus, codec-side handshake,
// bus and handshake assertions, and the closing result line
`default_nettype none

module enetAudioTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numPackets    = 8;
  localparam int maxWords      = 20;
  localparam int restartPacket = 5;
  localparam int initClocks    = 2 * enetAudioPkg::initSteps * (4 * enetAudioPkg::delayCycles + 8);
  localparam int watchdogClocks = numPackets * maxWords * 40 + initClocks;

  logic                         Clock;
  logic                         rstN;
  logic                         startInit;
  logic                         sampleReq;
  logic                         sampleAck;
  logic                         enetInt;
  logic                         enetRstN;
  enetAudioPkg::enetWord        audioSample;
  enetAudioPkg::enetWord        enetDataIn;
  enetAudioPkg::enetPins        pins;
  logic [7:0]                   pktSeq;
  enetAudioPkg::enetWord        pktLength;
  enetAudioPkg::enetWord [31:0] pktWords;
  int                           checks         = 0;
  int                           valueErrors    = 0;
  int                           protocolErrors = 0;

  // Register writes expected from one initialisation, cmd level above the data
  logic [16:0] expectedInit [0:10] = '{
    {1'b0, enetAudioPkg::regNetCtrlIdx},  {1'b1, enetAudioPkg::netCtrlReset},
    {1'b1, enetAudioPkg::netCtrlRelease}, {1'b0, enetAudioPkg::regPhyCtrlIdx},
    {1'b1, enetAudioPkg::phyPowerUp},     {1'b0, enetAudioPkg::regRxStatusIdx},
    {1'b1, enetAudioPkg::regRxStatusClear}, {1'b0, enetAudioPkg::regRxCtrlIdx},
    {1'b1, enetAudioPkg::rxCtrlEnable},   {1'b0, enetAudioPkg::regIntMaskIdx},
    {1'b1, enetAudioPkg::intMaskEnable}
  };

  enetAudioTop DUT (.*);
  enetChipModel chip (.*);

  initial begin
    Clock = 1'b0;
    forever #10 Clock = ~Clock;
  end

  // Bound covers every packet at full length plus two initialisations
  initial begin
    #(watchdogClocks * 20);
    $display("Watchdog expired at %0t before the test sequence finished", $time);
    $display("tests failed");
    $finish;
  end

  task automatic reportProtocolError(input string what);
    protocolErrors++;
    $display("Protocol error at %0t: %s", $time, what);
  endtask

  task automatic checkValue(input string name, input logic [16:0] observed,
                            input logic [16:0] expected);
    checks++;
    assert (observed === expected) else begin
      valueErrors++;
      $display("MISMATCH time=%0t %s expected=%h observed=%h", $time, name, expected, observed);
    end
  endtask

  function automatic enetAudioPkg::enetWord swapBytes(input enetAudioPkg::enetWord w);
    return {w[7:0], w[15:8]};
  endfunction

  task automatic checkInitLog(input logic [7:0] base);
    checkValue("init write count", 17'(chip.logCount - base), 17'd11);
    for (int k = 0; k < 11; k++) begin
      checkValue("init writeLog", chip.writeLog[base + 8'(k)], expectedInit[k]);
    end
  endtask

  // The header clears the interrupt and then selects the receive data register
  task automatic checkHeader();
    logic [7:0] last;
    last = chip.logCount;
    checkValue("enetInt", 17'(enetInt), 17'd0);
    checkValue("status index writeLog", chip.writeLog[last - 8'd3],
               {1'b0, enetAudioPkg::regRxStatusIdx});
    checkValue("status clear writeLog", chip.writeLog[last - 8'd2],
               {1'b1, enetAudioPkg::regRxStatusClear});
    checkValue("data index writeLog", chip.writeLog[last - 8'd1],
               {1'b0, enetAudioPkg::regRxDataIdx});
  endtask

  task automatic takeSample(output enetAudioPkg::enetWord value);
    @(posedge Clock);
    sampleReq <= 1'b1;
    do @(posedge Clock); while (!sampleAck);
    value = audioSample;
    sampleReq <= 1'b0;
    do @(posedge Clock); while (sampleAck);
  endtask

  task automatic pulseStartInit();
    @(posedge Clock);
    startInit <= 1'b1;
    @(posedge Clock);
    startInit <= 1'b0;
  endtask

  task automatic queuePacket(output int words);
    @(posedge Clock);
    words = $urandom_range(maxWords, 2);
    for (int k = 0; k < maxWords; k++) pktWords[k] <= enetAudioPkg::enetWord'($urandom);
    pktLength <= enetAudioPkg::enetWord'(2 * words);
    pktSeq    <= pktSeq + 8'd1;
  endtask

  // The chip reset pin mirrors the design reset, in and out of reset
  always @(negedge Clock) begin
    checkValue("enetRstN", 17'(enetRstN), 17'(rstN));
  end

  assert property (@(posedge Clock) disable iff (!rstN) pins.csN |-> (pins.wrN && pins.rdN))
    else reportProtocolError("strobe low while csN is high");
  assert property (@(posedge Clock) disable iff (!rstN) pins.wrN || pins.rdN)
    else reportProtocolError("wrN and rdN low together");
  assert property (@(posedge Clock) disable iff (!rstN)
    (!pins.wrN || !pins.rdN) |=> (pins.wrN && pins.rdN))
    else reportProtocolError("strobe longer than one clock");
  assert property (@(posedge Clock) disable iff (!rstN)
    (!pins.wrN || !pins.rdN) |-> (!$past(pins.csN) && $past(pins.wrN) && $past(pins.rdN)))
    else reportProtocolError("strobe without a setup clock");
  assert property (@(posedge Clock) disable iff (!rstN) !pins.wrN |-> pins.dataOutEnable)
    else reportProtocolError("write strobe without data drive");
  assert property (@(posedge Clock) disable iff (!rstN) pins.dataOutEnable |-> pins.rdN)
    else reportProtocolError("data driven during a read strobe");
  assert property (@(posedge Clock) disable iff (!rstN) $rose(sampleAck) |-> sampleReq)
    else reportProtocolError("sampleAck rose without sampleReq");
  assert property (@(posedge Clock) disable iff (!rstN) $fell(sampleAck) |-> !$past(sampleReq))
    else reportProtocolError("sampleAck fell before sampleReq");
  assert property (@(posedge Clock) disable iff (!rstN)
    (sampleAck && $past(sampleAck)) |-> $stable(audioSample))
    else reportProtocolError("audioSample changed while sampleAck is high");

  initial begin
    enetAudioPkg::enetWord got;
    enetAudioPkg::enetWord previous;
    logic [7:0]            logBase;
    int                    words;
    void'($urandom(32'h95a9_bb11));
    rstN      = 1'b0;
    startInit = 1'b0;
    sampleReq = 1'b0;
    pktSeq    = 8'd0;
    pktLength = 16'h0000;
    pktWords  = '0;
    repeat (8) @(posedge Clock);
    rstN <= 1'b1;
    // The first request is only answered once initialisation has finished
    pulseStartInit();
    takeSample(got);
    checkValue("audioSample", {1'b0, got}, 17'h0_0000);
    checkInitLog(8'd0);
    previous = got;
    for (int p = 0; p < numPackets; p++) begin
      if (p == restartPacket) begin
        logBase = chip.logCount;
        pulseStartInit();
        takeSample(got);
        checkValue("audioSample", {1'b0, got}, {1'b0, previous});
        checkInitLog(logBase);
      end
      queuePacket(words);
      for (int w = 0; w < words; w++) begin
        repeat ($urandom_range(5, 0)) @(posedge Clock);
        takeSample(got);
        if (w == 0) checkHeader();
        checkValue("audioSample", {1'b0, got}, {1'b0, swapBytes(pktWords[w])});
        previous = got;
      end
      // Nothing is pending now, so the last sample comes back unchanged
      takeSample(got);
      checkValue("audioSample", {1'b0, got}, {1'b0, previous});
    end
    $display("Checks %0d, value errors %0d, protocol errors %0d",
             checks, valueErrors, protocolErrors);
    if ((valueErrors == 0) && (protocolErrors == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
design/enetAudioPkg.sv
design/enetInitRom.sv
design/enetBusCycle.sv
design/enetRxControl.sv
design/enetAudioTop.sv
bench/enetChipModel.sv
bench/enetAudioTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module enetAudioTb \
  -f build.f -o enetAudioSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/enetAudioSim > sim.log 2>&1 && cat sim.log || { cat sim.log; exit 1; }
if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
